// ==== verilog/ebus_pkg.sv ====
`default_nettype none

// Widths and word types shared by every participant on the diagnostic bus
package ebus_pkg;

  // Full EBUS data path
  localparam int WORD_BITS = 36;

  // Diagnostic select field
  localparam int DS_BITS = 7;

  // The EDP board group splits the word into six-bit slices
  localparam int SLICE_BITS = 6;
  localparam int NUM_SLICES = 6;

  // One data word as carried on the EBUS, bit 0 least significant
  typedef logic [WORD_BITS-1:0] ebus_word_t;

  // Diagnostic select code
  typedef logic [DS_BITS-1:0] ebus_ds_t;

  // One EDP slice of a word
  typedef logic [SLICE_BITS-1:0] slice_t;

endpackage

`default_nettype wire

// ==== verilog/diag_map_pkg.sv ====
`default_nettype none

// Diagnostic select address map and board layout
package diag_map_pkg;

  // APR board answers four consecutive selects from here
  localparam ebus_pkg::ebus_ds_t DS_APR_BASE = 7'o040;

  // CON board, same layout as APR
  localparam ebus_pkg::ebus_ds_t DS_CON_BASE = 7'o050;

  // Single select shared by all six EDP slices
  localparam ebus_pkg::ebus_ds_t DS_EDP_AR = 7'o060;

  // Registers held by each diagnostic register board
  localparam int REGS_PER_BOARD = 4;

  // Index width into a board's register file
  localparam int REG_IDX_BITS = $clog2(REGS_PER_BOARD);

endpackage

`default_nettype wire

// ==== verilog/ebus_fe.sv ====
`timescale 1ns/10ps
`default_nettype none

module ebus_fe (
  input  wire logic                 clk,
  input  wire logic                 arst_n,

  input  wire logic                 cmd_strobe,
  input  wire logic                 cmd_write,
  input  wire ebus_pkg::ebus_ds_t   cmd_ds,
  input  wire ebus_pkg::ebus_word_t cmd_data,

  input  wire ebus_pkg::ebus_word_t ebus_data,

  output logic                      ebus_ds_strobe,
  output logic                      ebus_write,
  output ebus_pkg::ebus_ds_t        ebus_ds,
  output ebus_pkg::ebus_word_t      ebus_data_fe,

  output logic                      resp_strobe,
  output ebus_pkg::ebus_ds_t        resp_ds,
  output ebus_pkg::ebus_word_t      resp_data,
  output logic                      resp_par
);

  logic rd_cycle;

  // A read is on the bus when the strobe is up without write
  assign rd_cycle = ebus_ds_strobe & ~ebus_write;

  // Stage one, command onto the EBUS for exactly one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ebus_ds_strobe <= 1'b0;
      ebus_write     <= 1'b0;
    end else begin
      ebus_ds_strobe <= cmd_strobe;
      ebus_write     <= cmd_strobe & cmd_write;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_strobe) begin
      ebus_ds      <= cmd_ds;
      ebus_data_fe <= cmd_data;
    end
  end

  // Stage two, sample the muxed bus word at the end of a read cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      resp_strobe <= 1'b0;
    end else begin
      resp_strobe <= rd_cycle;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_cycle) begin
      resp_ds   <= ebus_ds;
      resp_data <= ebus_data;
      // Odd parity, so an all-zero word carries a one
      resp_par  <= ~^ebus_data;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/diag_reg_board.sv ====
`timescale 1ns/10ps
`default_nettype none

module diag_reg_board #(
  parameter ebus_pkg::ebus_ds_t BASE_DS = diag_map_pkg::DS_APR_BASE
) (
  input  wire logic                 clk,
  input  wire logic                 arst_n,
  input  wire logic                 ebus_ds_strobe,
  input  wire logic                 ebus_write,
  input  wire ebus_pkg::ebus_ds_t   ebus_ds,
  input  wire ebus_pkg::ebus_word_t ebus_data_fe,
  output logic                      driving,
  output ebus_pkg::ebus_word_t      data
);

  ebus_pkg::ebus_word_t regs [diag_map_pkg::REGS_PER_BOARD];
  ebus_pkg::ebus_ds_t   offset;
  logic [diag_map_pkg::REG_IDX_BITS-1:0] idx;
  logic                 hit;

  // Select decode, offset from base must land inside the board
  assign offset = ebus_ds - BASE_DS;
  assign idx    = offset[diag_map_pkg::REG_IDX_BITS-1:0];
  assign hit    = ebus_ds_strobe && (ebus_ds >= BASE_DS) &&
                  (offset < diag_map_pkg::REGS_PER_BOARD);

  assign driving = hit & ~ebus_write;
  assign data    = regs[idx];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < diag_map_pkg::REGS_PER_BOARD; i++) begin
        regs[i] <= '0;
      end
    end else if (hit && ebus_write) begin
      regs[idx] <= ebus_data_fe;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/edp_slice.sv ====
`timescale 1ns/10ps
`default_nettype none

module edp_slice #(
  parameter int SLICE = 0
) (
  input  wire logic                 clk,
  input  wire logic                 arst_n,
  input  wire logic                 ebus_ds_strobe,
  input  wire logic                 ebus_write,
  input  wire ebus_pkg::ebus_ds_t   ebus_ds,
  input  wire ebus_pkg::ebus_word_t ebus_data_fe,
  output logic                      driving,
  output ebus_pkg::slice_t          data
);

  ebus_pkg::slice_t ar;
  logic             sel;

  // Every slice decodes the same select, the word is shared six ways
  assign sel = ebus_ds_strobe && (ebus_ds == diag_map_pkg::DS_EDP_AR);

  assign driving = sel & ~ebus_write;
  assign data    = ar;

  // Keep only this slice's six bits of the bus word
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ar <= '0;
    end else if (sel && ebus_write) begin
      ar <= ebus_data_fe[SLICE*ebus_pkg::SLICE_BITS +: ebus_pkg::SLICE_BITS];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ebus_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

module ebus_mux (
  input  wire logic                             fe_driving,
  input  wire ebus_pkg::ebus_word_t             ebus_data_fe,
  input  wire logic                             apr_driving,
  input  wire ebus_pkg::ebus_word_t             apr_data,
  input  wire logic                             con_driving,
  input  wire ebus_pkg::ebus_word_t             con_data,
  input  wire logic [ebus_pkg::NUM_SLICES-1:0]  edp_driving,
  input  wire ebus_pkg::slice_t                 edp_data [ebus_pkg::NUM_SLICES],
  output ebus_pkg::ebus_word_t                  ebus_data
);

  ebus_pkg::ebus_word_t edp_word;

  // Slice 0 holds the least significant six bits
  always_comb begin
    for (int i = 0; i < ebus_pkg::NUM_SLICES; i++) begin
      edp_word[i*ebus_pkg::SLICE_BITS +: ebus_pkg::SLICE_BITS] = edp_data[i];
    end
  end

  // Fixed priority, front end first
  always_comb begin
    if (fe_driving) begin
      ebus_data = ebus_data_fe;
    end else if (apr_driving) begin
      ebus_data = apr_data;
    end else if (con_driving) begin
      ebus_data = con_data;
    end else if (|edp_driving) begin
      // Any one slice driving brings in the whole group
      ebus_data = edp_word;
    end else begin
      ebus_data = '0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/kl_ebus.sv ====
`timescale 1ns/10ps
`default_nettype none

module kl_ebus (
  input  wire logic                 clk,
  input  wire logic                 arst_n,

  input  wire logic                 cmd_strobe,
  input  wire logic                 cmd_write,
  input  wire ebus_pkg::ebus_ds_t   cmd_ds,
  input  wire ebus_pkg::ebus_word_t cmd_data,

  output logic                      resp_strobe,
  output ebus_pkg::ebus_ds_t        resp_ds,
  output ebus_pkg::ebus_word_t      resp_data,
  output logic                      resp_par
);

  wire logic                            ebus_ds_strobe;
  wire logic                            ebus_write;
  wire ebus_pkg::ebus_ds_t              ebus_ds;
  wire ebus_pkg::ebus_word_t            ebus_data_fe;
  wire ebus_pkg::ebus_word_t            ebus_data;
  wire logic                            fe_driving;

  wire logic                            apr_driving;
  wire ebus_pkg::ebus_word_t            apr_data;
  wire logic                            con_driving;
  wire ebus_pkg::ebus_word_t            con_data;
  wire logic [ebus_pkg::NUM_SLICES-1:0] edp_driving;
  wire ebus_pkg::slice_t                edp_data [ebus_pkg::NUM_SLICES];

  // Front end owns the data lines during a write
  assign fe_driving = ebus_ds_strobe & ebus_write;

  ebus_fe fe_i (.*);

  diag_reg_board #(.BASE_DS(diag_map_pkg::DS_APR_BASE)) apr_board (
    .clk, .arst_n, .ebus_ds_strobe, .ebus_write, .ebus_ds, .ebus_data_fe,
    .driving (apr_driving),
    .data    (apr_data)
  );

  diag_reg_board #(.BASE_DS(diag_map_pkg::DS_CON_BASE)) con_board (
    .clk, .arst_n, .ebus_ds_strobe, .ebus_write, .ebus_ds, .ebus_data_fe,
    .driving (con_driving),
    .data    (con_data)
  );

  // EDP AR word, one board per six bits
  for (genvar i = 0; i < ebus_pkg::NUM_SLICES; i++) begin : g_edp
    edp_slice #(.SLICE(i)) edp_i (
      .clk, .arst_n, .ebus_ds_strobe, .ebus_write, .ebus_ds, .ebus_data_fe,
      .driving (edp_driving[i]),
      .data    (edp_data[i])
    );
  end

  ebus_mux mux_i (
    .fe_driving, .ebus_data_fe,
    .apr_driving, .apr_data,
    .con_driving, .con_data,
    .edp_driving, .edp_data,
    .ebus_data
  );

endmodule

`default_nettype wire

// ==== tb/tb_kl_ebus.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_kl_ebus;

  localparam int BURST_LEN = 64;
  // Reset reads, APR/CON phase, EDP phase, unmapped reads, burst with its lead-in pair
  localparam int NUM_CMDS  = 9 + 24 + 2 + 7 + 2 + BURST_LEN;

  logic                 clk;
  logic                 arst_n;
  logic                 cmd_strobe;
  logic                 cmd_write;
  ebus_pkg::ebus_ds_t   cmd_ds;
  ebus_pkg::ebus_word_t cmd_data;
  logic                 resp_strobe;
  ebus_pkg::ebus_ds_t   resp_ds;
  ebus_pkg::ebus_word_t resp_data;
  logic                 resp_par;

  // Expected register contents by select code
  ebus_pkg::ebus_word_t model [128];

  // Outstanding reads, oldest first
  int                   exp_due [$];
  ebus_pkg::ebus_ds_t   exp_ds [$];
  ebus_pkg::ebus_word_t exp_word [$];
  logic                 exp_par [$];
  string                exp_name [$];

  ebus_pkg::ebus_ds_t unmapped [7] = '{7'o000, 7'o037, 7'o044, 7'o047, 7'o054, 7'o061, 7'o177};
  ebus_pkg::ebus_ds_t burst_codes [10] = '{7'o040, 7'o041, 7'o042, 7'o043, 7'o050,
                                            7'o051, 7'o052, 7'o053, 7'o060, 7'o077};

  logic [31:0] rng;
  int          neg_cnt = 0;
  int          errors = 0;
  int          checks = 0;

  kl_ebus dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic is_mapped(input ebus_pkg::ebus_ds_t ds);
    return (ds >= diag_map_pkg::DS_APR_BASE && ds < diag_map_pkg::DS_APR_BASE + 7'd4) ||
           (ds >= diag_map_pkg::DS_CON_BASE && ds < diag_map_pkg::DS_CON_BASE + 7'd4) ||
           (ds == diag_map_pkg::DS_EDP_AR);
  endfunction

  // Expected read word with its odd parity bit on top
  function automatic logic [36:0] ref_read(input ebus_pkg::ebus_ds_t ds);
    ebus_pkg::ebus_word_t w;
    logic                 p;
    w = is_mapped(ds) ? model[ds] : '0;
    // Parity bit brings the total count of ones to an odd number
    p = (($countones(w) % 2) == 0);
    return {p, w};
  endfunction

  task automatic rand_word(output ebus_pkg::ebus_word_t w);
    rng = xorshift32(rng);
    w[31:0] = rng;
    rng = xorshift32(rng);
    w[35:32] = rng[3:0];
  endtask

  task automatic issue_write(input ebus_pkg::ebus_ds_t ds, input ebus_pkg::ebus_word_t w);
    @(posedge clk);
    cmd_strobe <= 1'b1;
    cmd_write  <= 1'b1;
    cmd_ds     <= ds;
    cmd_data   <= w;
    if (is_mapped(ds)) begin
      model[ds] = w;
    end
  endtask

  task automatic issue_read(input ebus_pkg::ebus_ds_t ds, input string name);
    logic [36:0] e;
    @(posedge clk);
    cmd_strobe <= 1'b1;
    cmd_write  <= 1'b0;
    cmd_ds     <= ds;
    cmd_data   <= '0;
    e = ref_read(ds);
    // Sampled at the third falling edge from here, after the edge one cycle past the command edge
    exp_due.push_back(neg_cnt + 3);
    exp_ds.push_back(ds);
    exp_word.push_back(e[35:0]);
    exp_par.push_back(e[36]);
    exp_name.push_back(name);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      cmd_strobe <= 1'b0;
      cmd_write  <= 1'b0;
    end
  endtask

  task automatic drop_front();
    exp_due.delete(0);
    exp_ds.delete(0);
    exp_word.delete(0);
    exp_par.delete(0);
    exp_name.delete(0);
  endtask

  // Comparator, outputs are settled at the falling edge
  always @(negedge clk) begin
    neg_cnt = neg_cnt + 1;
    while (exp_due.size() > 0 && exp_due[0] < neg_cnt) begin
      $display("No response arrived for %s read of select %o", exp_name[0], exp_ds[0]);
      errors++;
      drop_front();
    end
    if (resp_strobe === 1'b1) begin
      if (exp_due.size() == 0 || exp_due[0] != neg_cnt) begin
        $display("Response strobe for select %o arrived with no read due", resp_ds);
        errors++;
      end else begin
        checks++;
        if (resp_ds !== exp_ds[0]) begin
          $display("CHECK FAILED %s ds: expected %o actual %o", exp_name[0], exp_ds[0], resp_ds);
          errors++;
        end
        if (resp_data !== exp_word[0]) begin
          $display("CHECK FAILED %s data: expected %o actual %o",
                   exp_name[0], exp_word[0], resp_data);
          errors++;
        end
        if (resp_par !== exp_par[0]) begin
          $display("CHECK FAILED %s par: expected %b actual %b",
                   exp_name[0], exp_par[0], resp_par);
          errors++;
        end
        if (^{resp_par, resp_data} !== 1'b1) begin
          $display("CHECK FAILED %s odd parity: expected 1 actual %b",
                   exp_name[0], ^{resp_par, resp_data});
          errors++;
        end
        drop_front();
      end
    end
  end

  initial begin
    ebus_pkg::ebus_word_t w;
    ebus_pkg::ebus_ds_t   ds;
    int                   pick;
    arst_n     = 1'b0;
    cmd_strobe = 1'b0;
    cmd_write  = 1'b0;
    cmd_ds     = '0;
    cmd_data   = '0;
    rng        = 32'd51;
    for (int i = 0; i < 128; i++) begin
      model[i] = '0;
    end
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    idle_cycles(2);

    for (int i = 0; i < 4; i++) begin
      issue_read(diag_map_pkg::DS_APR_BASE + 7'(i), "reset_apr");
      issue_read(diag_map_pkg::DS_CON_BASE + 7'(i), "reset_con");
    end
    issue_read(diag_map_pkg::DS_EDP_AR, "reset_edp");
    idle_cycles(1);

    // APR first, CON untouched must still read zero
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < 4; i++) begin
        rand_word(w);
        ds = (b == 0) ? diag_map_pkg::DS_APR_BASE : diag_map_pkg::DS_CON_BASE;
        issue_write(ds + 7'(i), w);
      end
      for (int i = 0; i < 4; i++) begin
        issue_read(diag_map_pkg::DS_APR_BASE + 7'(i), "board_apr");
        issue_read(diag_map_pkg::DS_CON_BASE + 7'(i), "board_con");
      end
      idle_cycles(1);
    end

    rand_word(w);
    issue_write(diag_map_pkg::DS_EDP_AR, w);
    issue_read(diag_map_pkg::DS_EDP_AR, "edp_order");
    idle_cycles(1);

    for (int i = 0; i < 7; i++) begin
      issue_read(unmapped[i], "unmapped");
    end
    idle_cycles(1);

    rand_word(w);
    issue_write(diag_map_pkg::DS_CON_BASE + 7'd2, w);
    issue_read(diag_map_pkg::DS_CON_BASE + 7'd2, "burst_raw");
    for (int i = 0; i < BURST_LEN; i++) begin
      rng = xorshift32(rng);
      pick = int'(rng % 32'd10);
      ds = burst_codes[pick];
      if (rng[16]) begin
        rand_word(w);
        issue_write(ds, w);
      end else begin
        issue_read(ds, "burst");
      end
    end
    idle_cycles(1);

    while (exp_due.size() > 0) begin
      @(posedge clk);
    end
    idle_cycles(2);
    $display("Responses checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the command count
  initial begin
    repeat (NUM_CMDS * 4 + 200) @(posedge clk);
    $display("Run timed out with %0d reads outstanding, errors: %0d", exp_due.size(), errors);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/ebus_pkg.sv
verilog/diag_map_pkg.sv
verilog/ebus_fe.sv
verilog/diag_reg_board.sv
verilog/edp_slice.sv
verilog/ebus_mux.sv
verilog/kl_ebus.sv
tb/tb_kl_ebus.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the EBUS testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_kl_ebus -Mdir obj_dir -f build.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_kl_ebus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Result is decided by the pass line in the log
if grep -qx "ALL CHECKS PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi
